// File: bench/tb_dvbs_tx_model.svh
`ifndef TB_DVBS_TX_MODEL_SVH
`define TB_DVBS_TX_MODEL_SVH

logic        mdl_mode; // 1 is bpsk
logic        mdl_inv;
logic        mdl_en;
logic [15:0] mdl_amp;
logic [31:0] mdl_cnt [4]; // bytes in, dropped, symbols out, fs_en pulses

function automatic void model_reset();
	mdl_mode = 1'b0;
	mdl_inv  = 1'b0;
	mdl_en   = 1'b1;
	mdl_amp  = 16'd23170;
	for (int i = 0; i < 4; i++) mdl_cnt[i] = 32'd0;
endfunction

function automatic void model_write(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
	logic [31:0] word;
	word = expected_readback(addr);
	for (int lane = 0; lane < 4; lane++) begin
		if (strb[lane]) word[8*lane +: 8] = data[8*lane +: 8];
	end
	case (addr)
		4'd0:    mdl_mode = word[0];
		4'd1:    mdl_inv  = word[0];
		4'd2:    mdl_en   = word[0];
		4'd3:    mdl_amp  = word[15:0]; // upper half is not stored
		default: ; // counters and holes ignore writes
	endcase
endfunction

function automatic logic [31:0] expected_readback(input logic [3:0] addr);
	case (addr)
		4'd0:    return {31'b0, mdl_mode};
		4'd1:    return {31'b0, mdl_inv};
		4'd2:    return {31'b0, mdl_en};
		4'd3:    return {16'b0, mdl_amp};
		4'd4:    return mdl_cnt[0];
		4'd5:    return mdl_cnt[1];
		4'd6:    return mdl_cnt[2];
		4'd7:    return mdl_cnt[3] - mdl_cnt[2]; // pulses that found nothing to send
		default: return {16'hE000, 12'h000, addr};
	endcase
endfunction

function automatic int symbols_per_byte(input logic bpsk);
	return bpsk ? 8 : 4;
endfunction

// symbol k of a byte, msb first, as {re, im}
function automatic logic [31:0] expected_symbol(input logic [7:0] b, input logic bpsk,
		input logic [15:0] amp, input logic inv, input int k);
	logic [15:0] pos;
	logic [15:0] neg;
	logic [15:0] re;
	logic [15:0] im;
	pos = amp;
	neg = 16'd0 - amp;
	if (bpsk) begin
		re = b[7-k] ? neg : pos;
		im = 16'd0;
	end else begin
		re = b[7-2*k] ? neg : pos;
		im = b[6-2*k] ? neg : pos;
	end
	if (inv) return {im, re};
	else return {re, im};
endfunction

`endif

// File: bench/tb_dvbs_tx.sv
`timescale 1ns/100ps

module tb_dvbs_tx;
	import dvbs_pkg::*;

	logic      clk;
	logic      hard_rst_n;
	logic      wen;
	reg_addr_t waddr;
	reg_data_t wdata;
	reg_strb_t wstrb;
	logic      ren;
	reg_addr_t raddr;
	logic      ts_valid;
	ts_byte_t  ts_din;
	logic      fs_en;
	reg_data_t rdata;
	logic      symbol_oe;
	sample_t   symbol_re;
	sample_t   symbol_im;

	integer      seed;
	logic [31:0] exp_q [$]; // {re, im} in output order
	logic [31:0] head_sym;
	int          fs_div;    // fs_en every fs_div cycles, 0 stops it
	int          fs_phase;
	int          busy_left; // mapper still refuses bytes while nonzero

	`include "tb_dvbs_tx_model.svh"

	dvbs_tx_top #(.FIFO_DEPTH_LOG2(4)) dut (.*);

	always #50 clk = ~clk;

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic give_up(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic tick();
		@(negedge clk);
		ts_valid = 1'b0;
		if (busy_left > 0) busy_left--;
	endtask

	task automatic drive_byte(input logic valid, input ts_byte_t b);
		int spb;
		int k;
		tick();
		ts_valid = valid;
		ts_din   = b;
		spb      = symbols_per_byte(mdl_mode);
		if (valid && mdl_en && busy_left == 0) begin
			mdl_cnt[0] = mdl_cnt[0] + 1;
			mdl_cnt[2] = mdl_cnt[2] + spb;
			for (k = 0; k < spb; k++) begin
				exp_q.push_back(expected_symbol(b, mdl_mode, mdl_amp, mdl_inv, k));
			end
			busy_left = spb + 1; // busy up to the cycle of its last push
		end else if (valid && mdl_en) begin
			mdl_cnt[1] = mdl_cnt[1] + 1;
		end
	endtask

	task automatic send_bytes(input int n, input int gap);
		for (int i = 0; i < n; i++) begin
			drive_byte(1'b1, $random(seed));
			repeat (gap) drive_byte(1'b0, 8'h00);
		end
	endtask

	task automatic host_write(input reg_addr_t a, input reg_data_t d, input reg_strb_t s);
		tick();
		wen   = 1'b1;
		waddr = a;
		wdata = d;
		wstrb = s;
		tick();
		wen = 1'b0;
		tick(); // second write stage has landed
		model_write(a, d, s);
	endtask

	task automatic read_check(input reg_addr_t a);
		tick();
		ren   = 1'b1;
		raddr = a;
		tick();
		ren = 1'b0;
		check($sformatf("rdata@%0d", a), expected_readback(a), rdata);
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			tick();
			n++;
			if (n > limit) give_up("timeout: expected symbols never left the pacer");
		end
	endtask

	task automatic stop_fs();
		fs_div = 0;
		repeat (4) tick(); // last underflow and symbol reach the counters
	endtask

	always @(negedge clk) begin
		if (fs_div > 0 && (fs_phase % fs_div) == 0) begin
			fs_en      = 1'b1;
			mdl_cnt[3] = mdl_cnt[3] + 1;
		end else begin
			fs_en = 1'b0;
		end
		fs_phase++;
	end

	// every symbol_oe must match the oldest expected symbol
	always @(negedge clk) begin
		if (hard_rst_n === 1'b1 && symbol_oe === 1'b1) begin
			if (exp_q.size() == 0) begin
				give_up("symbol_oe was high with no symbol expected");
			end else begin
				head_sym = exp_q.pop_front();
				check("symbol_re,symbol_im", head_sym, {symbol_re, symbol_im});
			end
		end
	end

	initial begin
		int i;
		seed       = 32'h6a49_033e;
		clk        = 1'b0;
		hard_rst_n = 1'b0;
		wen        = 1'b0;
		waddr      = '0;
		wdata      = '0;
		wstrb      = '0;
		ren        = 1'b0;
		raddr      = '0;
		ts_valid   = 1'b0;
		ts_din     = '0;
		fs_en      = 1'b0;
		fs_div     = 0;
		fs_phase   = 0;
		busy_left  = 0;
		model_reset();
		repeat (8) @(negedge clk);
		hard_rst_n = 1'b1;
		check("rdata", 32'h0, rdata);
		for (i = 0; i < 16; i++) read_check(reg_addr_t'(i));

		host_write(ADDR_AMPLITUDE, 32'h1234_5678, 4'b0001);
		read_check(ADDR_AMPLITUDE);
		host_write(ADDR_AMPLITUDE, 32'hAABB_3C00, 4'b1110);
		read_check(ADDR_AMPLITUDE);
		host_write(ADDR_FREQ_INV, 32'h0000_0101, 4'b0010); // bit 0 lane not strobed
		host_write(ADDR_BYTES_IN, 32'hFFFF_FFFF, 4'b1111);
		host_write(ADDR_UNDERFLOW, 32'h0000_00FF, 4'b0001);
		host_write(4'd11, 32'h0000_1234, 4'b1111);
		for (i = 0; i < 16; i++) read_check(reg_addr_t'(i));

		// qpsk, bpsk, then both again with i/q swapped
		for (i = 0; i < 4; i++) begin
			host_write(ADDR_MOD_MODE, i % 2, 4'b0001);
			host_write(ADDR_FREQ_INV, i / 2, 4'b0001);
			host_write(ADDR_AMPLITUDE, 3000 + i * 4000, 4'b0011);
			fs_div = 2;
			send_bytes(10, 20);
			wait_drain(200);
		end

		host_write(ADDR_FREQ_INV, 32'd0, 4'b0001);
		fs_div = 1;
		send_bytes(30, 0); // back to back in bpsk
		host_write(ADDR_TX_ENABLE, 32'd0, 4'b0001);
		send_bytes(12, 0);
		host_write(ADDR_TX_ENABLE, 32'd1, 4'b0001);
		host_write(ADDR_MOD_MODE, 32'd0, 4'b0001);
		send_bytes(30, 0);
		wait_drain(200);
		stop_fs();
		for (i = 4; i < 8; i++) read_check(reg_addr_t'(i));

		fs_div = 3; // no traffic, every pulse underflows
		repeat (30) tick();
		stop_fs();
		read_check(ADDR_UNDERFLOW);
		read_check(ADDR_SYMS_OUT);

		$display("Test OK");
		$finish;
	end

endmodule

// File: hw/dvbs_cfg_regs.sv
`timescale 1ns/100ps

module dvbs_cfg_regs (
	input  logic                clk,
	input  logic                hard_rst_n,
	input  logic                wen,
	input  dvbs_pkg::reg_addr_t waddr,
	input  dvbs_pkg::reg_data_t wdata,
	input  dvbs_pkg::reg_strb_t wstrb,
	input  logic                ren,
	input  dvbs_pkg::reg_addr_t raddr,
	input  logic                byte_accepted,
	input  logic                byte_dropped,
	input  logic                symbol_oe,
	input  logic                underflow,
	output dvbs_pkg::reg_data_t rdata,
	output dvbs_pkg::tx_cfg_t   cfg
);
	import dvbs_pkg::*;

	// first write stage, latched host request
	logic      wr_en_q;
	reg_addr_t wr_addr_q;
	reg_data_t wr_data_q;
	reg_strb_t wr_strb_q;

	// control fields, only the meaningful bits are kept
	mod_mode_e   mod_mode_q;
	logic        freq_inv_q;
	logic        tx_enable_q;
	logic [15:0] amplitude_q;

	reg_data_t cur_word; // addressed register before merge
	reg_data_t new_word; // after lane merge

	// 0 bytes in, 1 bytes dropped, 2 symbols out, 3 underflows
	reg_data_t  cnt_q [4];
	logic [3:0] cnt_inc;

	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			wr_en_q <= 1'b0;
		end else begin
			wr_en_q <= wen;
		end
		if (wen) begin
			wr_addr_q <= waddr;
			wr_data_q <= wdata;
			wr_strb_q <= wstrb;
		end
	end

	always_comb begin
		case (wr_addr_q)
			ADDR_MOD_MODE:  cur_word = {31'b0, mod_mode_q};
			ADDR_FREQ_INV:  cur_word = {31'b0, freq_inv_q};
			ADDR_TX_ENABLE: cur_word = {31'b0, tx_enable_q};
			ADDR_AMPLITUDE: cur_word = {16'b0, amplitude_q};
			default:        cur_word = '0; // counters and holes are not writable
		endcase
		new_word = cur_word;
		for (int lane = 0; lane < 4; lane++) begin
			if (wr_strb_q[lane]) begin
				new_word[8*lane +: 8] = wr_data_q[8*lane +: 8];
			end
		end
	end

	// second write stage
	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			mod_mode_q  <= DEF_MOD_MODE;
			freq_inv_q  <= DEF_FREQ_INV;
			tx_enable_q <= DEF_TX_ENABLE;
			amplitude_q <= DEF_AMPLITUDE;
		end else if (wr_en_q) begin
			case (wr_addr_q)
				ADDR_MOD_MODE:  mod_mode_q  <= mod_mode_e'(new_word[0]);
				ADDR_FREQ_INV:  freq_inv_q  <= new_word[0];
				ADDR_TX_ENABLE: tx_enable_q <= new_word[0];
				ADDR_AMPLITUDE: amplitude_q <= new_word[15:0];
				default: ;
			endcase
		end
	end

	assign cnt_inc = {underflow, symbol_oe, byte_dropped, byte_accepted};

	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (!hard_rst_n) begin
				cnt_q[i] <= '0;
			end else if (cnt_inc[i]) begin
				cnt_q[i] <= cnt_q[i] + 1'b1; // wraps
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			rdata <= '0;
		end else if (ren) begin
			case (raddr)
				ADDR_MOD_MODE:   rdata <= {31'b0, mod_mode_q};
				ADDR_FREQ_INV:   rdata <= {31'b0, freq_inv_q};
				ADDR_TX_ENABLE:  rdata <= {31'b0, tx_enable_q};
				ADDR_AMPLITUDE:  rdata <= {16'b0, amplitude_q};
				ADDR_BYTES_IN:   rdata <= cnt_q[0];
				ADDR_BYTES_DROP: rdata <= cnt_q[1];
				ADDR_SYMS_OUT:   rdata <= cnt_q[2];
				ADDR_UNDERFLOW:  rdata <= cnt_q[3];
				default:         rdata <= {UNMAPPED_TAG, 12'h000, raddr}; // tagged hole
			endcase
		end
	end

	always_comb begin
		cfg           = '0;
		cfg.tx_enable = tx_enable_q;
		cfg.mod_mode  = mod_mode_q;
		cfg.freq_inv  = freq_inv_q;
		cfg.amplitude = amplitude_q;
		cfg.spare     = 1'b0;
	end

endmodule

// File: hw/dvbs_pkg.sv
package dvbs_pkg;

	// host port widths
	typedef logic [3:0]  reg_addr_t;
	typedef logic [31:0] reg_data_t;
	typedef logic [3:0]  reg_strb_t;

	// datapath widths
	typedef logic signed [15:0] sample_t;
	typedef logic [7:0]         ts_byte_t;

	typedef enum logic {
		MOD_QPSK = 1'b0, // 2 bits per symbol
		MOD_BPSK = 1'b1  // 1 bit per symbol
	} mod_mode_e;

	typedef struct packed {
		sample_t re;
		sample_t im;
	} symbol_t;

	typedef struct packed {
		logic       tx_enable;
		mod_mode_e  mod_mode;
		logic       freq_inv;  // swap i and q at the output
		logic [15:0] amplitude; // unsigned magnitude
		logic       spare;
	} tx_cfg_t;

	// register map, word addresses
	localparam reg_addr_t ADDR_MOD_MODE   = 4'd0;
	localparam reg_addr_t ADDR_FREQ_INV   = 4'd1;
	localparam reg_addr_t ADDR_TX_ENABLE  = 4'd2;
	localparam reg_addr_t ADDR_AMPLITUDE  = 4'd3;
	localparam reg_addr_t ADDR_BYTES_IN   = 4'd4;
	localparam reg_addr_t ADDR_BYTES_DROP = 4'd5;
	localparam reg_addr_t ADDR_SYMS_OUT   = 4'd6;
	localparam reg_addr_t ADDR_UNDERFLOW  = 4'd7;

	// values after reset
	localparam mod_mode_e   DEF_MOD_MODE  = MOD_QPSK;
	localparam logic        DEF_FREQ_INV  = 1'b0;
	localparam logic        DEF_TX_ENABLE = 1'b1;
	localparam logic [15:0] DEF_AMPLITUDE = 16'd23170; // about 0.707 of full scale

	// upper half of readback for unused addresses
	localparam logic [15:0] UNMAPPED_TAG = 16'hE000;

endpackage

// File: hw/dvbs_symbol_fifo.sv
`timescale 1ns/100ps

module dvbs_symbol_fifo #(
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	input  logic              clk,
	input  logic              hard_rst_n,
	input  logic              sym_push,
	input  dvbs_pkg::symbol_t sym_in,
	input  logic              sym_pop,
	output dvbs_pkg::symbol_t sym_out,
	output logic              fifo_empty,
	output logic              fifo_full
);
	import dvbs_pkg::*;

	localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

	symbol_t mem [DEPTH];

	logic [FIFO_DEPTH_LOG2-1:0] wr_ptr_q;
	logic [FIFO_DEPTH_LOG2-1:0] rd_ptr_q;
	logic [FIFO_DEPTH_LOG2:0]   count_q; // one extra bit for full

	logic do_push;
	logic do_pop;

	assign do_push = sym_push && !fifo_full;  // push on full is lost
	assign do_pop  = sym_pop && !fifo_empty;

	assign fifo_empty = (count_q == '0);
	assign fifo_full  = (count_q == DEPTH[FIFO_DEPTH_LOG2:0]);
	assign sym_out    = mem[rd_ptr_q]; // head entry

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr_q] <= sym_in;
		end
	end

	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q; // both or neither
			endcase
		end
	end

endmodule

// File: hw/dvbs_symbol_mapper.sv
`timescale 1ns/100ps

module dvbs_symbol_mapper (
	input  logic               clk,
	input  logic               hard_rst_n,
	input  logic               ts_valid,
	input  dvbs_pkg::ts_byte_t ts_din,
	input  dvbs_pkg::tx_cfg_t  cfg,
	input  logic               fifo_full,
	output logic               sym_push,
	output dvbs_pkg::symbol_t  sym_in,
	output logic               byte_accepted,
	output logic               byte_dropped
);
	import dvbs_pkg::*;

	typedef enum logic {
		IDLE,
		EMIT
	} map_state_e;

	map_state_e  state_q;
	logic [2:0]  sym_left_q; // symbols still to push after the current one
	ts_byte_t    shreg_q;    // msb is the next bit out
	mod_mode_e   mode_q;
	logic [15:0] amp_q;

	sample_t pos_amp;
	sample_t neg_amp;
	logic    take_byte;

	assign take_byte     = ts_valid && cfg.tx_enable && (state_q == IDLE);
	assign byte_accepted = take_byte;
	assign byte_dropped  = ts_valid && cfg.tx_enable && (state_q == EMIT);

	// fifo full holds the current symbol
	assign sym_push = (state_q == EMIT) && !fifo_full;

	assign pos_amp = sample_t'(amp_q);
	assign neg_amp = -pos_amp;

	always_comb begin
		sym_in.re = shreg_q[7] ? neg_amp : pos_amp;
		if (mode_q == MOD_QPSK) begin
			sym_in.im = shreg_q[6] ? neg_amp : pos_amp;
		end else begin
			sym_in.im = '0; // bpsk is real only
		end
	end

	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			state_q    <= IDLE;
			sym_left_q <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (take_byte) begin
						state_q    <= EMIT;
						sym_left_q <= (cfg.mod_mode == MOD_QPSK) ? 3'd3 : 3'd7;
					end
				end
				EMIT: begin
					if (sym_push) begin
						if (sym_left_q == 3'd0) begin
							state_q <= IDLE;
						end else begin
							sym_left_q <= sym_left_q - 1'b1;
						end
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// byte and settings are sampled at acceptance
	always_ff @(posedge clk) begin
		if (take_byte) begin
			shreg_q <= ts_din;
			mode_q  <= cfg.mod_mode;
			amp_q   <= cfg.amplitude;
		end else if (sym_push) begin
			shreg_q <= (mode_q == MOD_QPSK) ? {shreg_q[5:0], 2'b00} : {shreg_q[6:0], 1'b0};
		end
	end

endmodule

// File: hw/dvbs_symbol_pacer.sv
`timescale 1ns/100ps

module dvbs_symbol_pacer (
	input  logic              clk,
	input  logic              hard_rst_n,
	input  logic              fs_en,
	input  dvbs_pkg::tx_cfg_t cfg,
	input  dvbs_pkg::symbol_t sym_out,
	input  logic              fifo_empty,
	output logic              sym_pop,
	output logic              symbol_oe,
	output dvbs_pkg::sample_t symbol_re,
	output dvbs_pkg::sample_t symbol_im,
	output logic              underflow
);
	import dvbs_pkg::*;

	sample_t next_re;
	sample_t next_im;

	// one pop per symbol-rate pulse
	assign sym_pop = fs_en && !fifo_empty;

	// spectrum inversion by i/q swap
	always_comb begin
		if (cfg.freq_inv) begin
			next_re = sym_out.im;
			next_im = sym_out.re;
		end else begin
			next_re = sym_out.re;
			next_im = sym_out.im;
		end
	end

	always_ff @(posedge clk) begin
		if (!hard_rst_n) begin
			symbol_oe <= 1'b0;
			underflow <= 1'b0;
		end else begin
			symbol_oe <= sym_pop;
			underflow <= fs_en && fifo_empty; // pulse with nothing to send
		end
	end

	// output samples valid while symbol_oe is high
	always_ff @(posedge clk) begin
		if (sym_pop) begin
			symbol_re <= next_re;
			symbol_im <= next_im;
		end
	end

endmodule

// File: hw/dvbs_tx_top.sv
`timescale 1ns/100ps

module dvbs_tx_top #(
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	input  logic                clk,
	input  logic                hard_rst_n,
	input  logic                wen,
	input  dvbs_pkg::reg_addr_t waddr,
	input  dvbs_pkg::reg_data_t wdata,
	input  dvbs_pkg::reg_strb_t wstrb,
	input  logic                ren,
	input  dvbs_pkg::reg_addr_t raddr,
	input  logic                ts_valid,
	input  dvbs_pkg::ts_byte_t  ts_din,
	input  logic                fs_en,
	output dvbs_pkg::reg_data_t rdata,
	output logic                symbol_oe,
	output dvbs_pkg::sample_t   symbol_re,
	output dvbs_pkg::sample_t   symbol_im
);
	import dvbs_pkg::*;

	tx_cfg_t cfg;

	logic    byte_accepted;
	logic    byte_dropped;
	logic    underflow;

	logic    sym_push;
	symbol_t sym_in;
	logic    sym_pop;
	symbol_t sym_out;
	logic    fifo_empty;
	logic    fifo_full;

	dvbs_cfg_regs u_cfg_regs (
		.clk           (clk),
		.hard_rst_n    (hard_rst_n),
		.wen           (wen),
		.waddr         (waddr),
		.wdata         (wdata),
		.wstrb         (wstrb),
		.ren           (ren),
		.raddr         (raddr),
		.byte_accepted (byte_accepted),
		.byte_dropped  (byte_dropped),
		.symbol_oe     (symbol_oe),
		.underflow     (underflow),
		.rdata         (rdata),
		.cfg           (cfg)
	);

	dvbs_symbol_mapper u_mapper (
		.clk           (clk),
		.hard_rst_n    (hard_rst_n),
		.ts_valid      (ts_valid),
		.ts_din        (ts_din),
		.cfg           (cfg),
		.fifo_full     (fifo_full),
		.sym_push      (sym_push),
		.sym_in        (sym_in),
		.byte_accepted (byte_accepted),
		.byte_dropped  (byte_dropped)
	);

	dvbs_symbol_fifo #(
		.FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
	) u_fifo (
		.clk        (clk),
		.hard_rst_n (hard_rst_n),
		.sym_push   (sym_push),
		.sym_in     (sym_in),
		.sym_pop    (sym_pop),
		.sym_out    (sym_out),
		.fifo_empty (fifo_empty),
		.fifo_full  (fifo_full)
	);

	dvbs_symbol_pacer u_pacer (
		.clk        (clk),
		.hard_rst_n (hard_rst_n),
		.fs_en      (fs_en),
		.cfg        (cfg),
		.sym_out    (sym_out),
		.fifo_empty (fifo_empty),
		.sym_pop    (sym_pop),
		.symbol_oe  (symbol_oe),
		.symbol_re  (symbol_re),
		.symbol_im  (symbol_im),
		.underflow  (underflow)
	);

endmodule

// File: list.f
+incdir+bench
hw/dvbs_pkg.sv
hw/dvbs_cfg_regs.sv
hw/dvbs_symbol_mapper.sv
hw/dvbs_symbol_fifo.sv
hw/dvbs_symbol_pacer.sv
hw/dvbs_tx_top.sv
bench/tb_dvbs_tx.sv
